// File: hw/dsp_pkg.sv
// ========================================
// dsp shared definitions
// converter widths, channel and core counts,
// accumulator word and sequencer states
// ========================================

package dsp_pkg;

	// converter words
	localparam int adc_w = 64;
	localparam int dac_w = 256;
	localparam int sample_w = 16;
	localparam int n_dac = 4;

	// readout and processor counts
	localparam int n_chan = 2;
	localparam int n_core = 2;

	// accumulation buffer
	localparam int acc_half_w = 32;
	localparam int accbuf_addr_w = 8;

	// control widths
	localparam int shot_w = 32;
	localparam int shift_w = 5;
	localparam int bbsel_w = 2;

	// one buffer word seen raw or as the x/y pair
	typedef union packed {
		logic [2*acc_half_w-1:0] raw;
		struct packed {
			logic signed [acc_half_w-1:0] x;
			logic signed [acc_half_w-1:0] y;
		} xy;
	} acc_word_t;

	// gray-ish encoding along the shot path
	typedef enum logic [3:0] {
		idle      = 4'b0000,
		start     = 4'b0001,
		proc_run  = 4'b0011,
		elem_busy = 4'b0010,
		more_shot = 4'b0110,
		shot_add  = 4'b0111,
		done      = 4'b0101
	} seq_state_t;

endpackage

// File: hw/baseband_select.sv
// ========================================
// baseband source select
// registers adc and dac words, undersamples
// the dacs, picks two baseband streams
// ========================================

module baseband_select (
	input  logic dspif,
	input  logic reset,
	input  logic [dsp_pkg::adc_w-1:0] adc,
	input  logic [dsp_pkg::dac_w-1:0] dac [dsp_pkg::n_dac],
	input  logic [dsp_pkg::bbsel_w-1:0] mixbb1_sel,
	input  logic [dsp_pkg::bbsel_w-1:0] mixbb2_sel,
	output logic [dsp_pkg::adc_w-1:0] mixbb [dsp_pkg::n_chan]
);
	import dsp_pkg::*;

	// stage one outputs
	logic [adc_w-1:0] adc_r;
	logic [adc_w-1:0] dac_us [n_dac];

	// one selector per stream
	logic [bbsel_w-1:0] sel [n_chan];

	assign sel[0] = mixbb1_sel;
	assign sel[1] = mixbb2_sel;

	// input register stage
	always_ff @(posedge dspif) begin
		adc_r <= adc;
		for (int d = 0; d < n_dac; d++) begin
			for (int k = 0; k < adc_w / sample_w; k++) begin
				// keep samples 0, 4, 8, 12 of the wide dac word
				dac_us[d][k*sample_w +: sample_w] <=
					dac[d][k*(dac_w/adc_w)*sample_w +: sample_w];
			end
		end
	end

	// select stage
	// stream 0 sees dac 0/1 and stream 1 sees dac 2/3
	always_ff @(posedge dspif) begin
		if (reset) begin
			for (int c = 0; c < n_chan; c++) begin
				mixbb[c] <= '0;
			end
		end else begin
			for (int c = 0; c < n_chan; c++) begin
				case (sel[c])
					2'd0: mixbb[c] <= adc_r;
					2'd1: mixbb[c] <= dac_us[2*c];
					2'd2: mixbb[c] <= dac_us[2*c+1];
					// unused code holds the last stream
					default: mixbb[c] <= mixbb[c];
				endcase
			end
		end
	end

endmodule

// File: hw/readout_accumulator.sv
// ========================================
// readout accumulator
// fs/4 demodulation of each baseband stream,
// gated accumulation, shifted result strobe
// ========================================

module readout_accumulator (
	input  logic dspif,
	input  logic reset,
	input  logic [dsp_pkg::adc_w-1:0] mixbb [dsp_pkg::n_chan],
	input  logic [dsp_pkg::n_chan-1:0] gate,
	input  logic [dsp_pkg::shift_w-1:0] shift,
	output logic [dsp_pkg::n_chan-1:0] acc_valid,
	output dsp_pkg::acc_word_t acc_data [dsp_pkg::n_chan]
);
	import dsp_pkg::*;

	// running sums
	logic signed [acc_half_w-1:0] sum_x [n_chan];
	logic signed [acc_half_w-1:0] sum_y [n_chan];

	// per-word demodulated increments
	logic signed [acc_half_w-1:0] dx [n_chan];
	logic signed [acc_half_w-1:0] dy [n_chan];

	logic [n_chan-1:0] gate_d;
	logic [n_chan-1:0] gate_fall;

	// sample k of a 4-sample word, signed
	function automatic logic signed [sample_w-1:0] sample_at(
		input logic [adc_w-1:0] word,
		input int k
	);
		return word[k*sample_w +: sample_w];
	endfunction

	// lo at fs/4 is 1, -j, -1, +j over the four samples
	always_comb begin
		for (int i = 0; i < n_chan; i++) begin
			dx[i] = sample_at(mixbb[i], 0) - sample_at(mixbb[i], 2);
			dy[i] = sample_at(mixbb[i], 3) - sample_at(mixbb[i], 1);
		end
	end

	// first low cycle after the window
	assign gate_fall = gate_d & ~gate;

	always_ff @(posedge dspif) begin
		if (reset) begin
			gate_d <= '0;
			acc_valid <= '0;
			for (int i = 0; i < n_chan; i++) begin
				sum_x[i] <= '0;
				sum_y[i] <= '0;
			end
		end else begin
			gate_d <= gate;
			acc_valid <= gate_fall;
			for (int i = 0; i < n_chan; i++) begin
				if (gate_fall[i]) begin
					// result moves out and the sums start over
					sum_x[i] <= '0;
					sum_y[i] <= '0;
				end else if (gate[i]) begin
					sum_x[i] <= sum_x[i] + dx[i];
					sum_y[i] <= sum_y[i] + dy[i];
				end
			end
		end
	end

	// arithmetic shift keeps the sign of the result
	always_ff @(posedge dspif) begin
		for (int i = 0; i < n_chan; i++) begin
			if (gate_fall[i]) begin
				acc_data[i].xy.x <= sum_x[i] >>> shift;
				acc_data[i].xy.y <= sum_y[i] >>> shift;
			end
		end
	end

endmodule

// File: hw/accbuf_writer.sv
// ========================================
// accumulation buffer writer
// write strobe, locking address counter
// and measurement bit for feedback
// ========================================

module accbuf_writer (
	input  logic dspif,
	input  logic reset,
	input  logic [dsp_pkg::n_chan-1:0] acc_valid,
	input  dsp_pkg::acc_word_t acc_data [dsp_pkg::n_chan],
	input  logic resetacc,
	output logic [dsp_pkg::n_chan-1:0] we_accbuf,
	output logic [dsp_pkg::accbuf_addr_w-1:0] addr_accbuf [dsp_pkg::n_chan],
	output logic [2*dsp_pkg::acc_half_w-1:0] data_accbuf [dsp_pkg::n_chan],
	output logic [dsp_pkg::n_chan-1:0] meas,
	output logic [dsp_pkg::n_chan-1:0] meas_valid
);
	import dsp_pkg::*;

	logic resetacc_r;
	// word being written and kept for the measurement
	acc_word_t word_r [n_chan];

	always_comb begin
		for (int i = 0; i < n_chan; i++) begin
			data_accbuf[i] = word_r[i].raw;
		end
	end

	always_ff @(posedge dspif) begin
		for (int i = 0; i < n_chan; i++) begin
			if (acc_valid[i]) begin
				word_r[i] <= acc_data[i];
			end
		end
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			resetacc_r <= 1'b0;
			we_accbuf <= '0;
			meas <= '0;
			meas_valid <= '0;
			for (int i = 0; i < n_chan; i++) begin
				addr_accbuf[i] <= '0;
			end
		end else begin
			resetacc_r <= resetacc;
			we_accbuf <= acc_valid;
			meas_valid <= we_accbuf;
			for (int i = 0; i < n_chan; i++) begin
				// threshold on the real axis
				meas[i] <= word_r[i].xy.x[acc_half_w-1];
				// clear wins over a write in the same cycle
				if (resetacc_r) begin
					addr_accbuf[i] <= '0;
				end else if (we_accbuf[i] && !(&addr_accbuf[i])) begin
					addr_accbuf[i] <= addr_accbuf[i] + 1'b1;
				end
			end
		end
	end

endmodule

// File: hw/shot_sequencer.sv
// ========================================
// multi-shot sequencer
// runs the cores nshot times with resets
// in between, counts completed shots
// ========================================

module shot_sequencer (
	input  logic dspif,
	input  logic reset,
	input  logic stb_start,
	input  logic [dsp_pkg::shot_w-1:0] nshot,
	input  logic [dsp_pkg::n_core-1:0] procdone_core,
	input  logic [dsp_pkg::n_core-1:0] nobusy_core,
	output logic proc_start,
	output logic proc_reset,
	output logic proc_done,
	output logic last_shot_done,
	output logic [dsp_pkg::shot_w-1:0] shot_count
);
	import dsp_pkg::*;

	seq_state_t state;
	seq_state_t next_state;

	logic stb_start_r;
	logic [shot_w-1:0] nshot_r;
	logic [shot_w-1:0] shot_cnt;
	logic [shot_w-1:0] next_shot_cnt;
	// decided long before more_shot is reached
	logic shot_more;
	logic procdone_r;
	logic nobusy_r;

	always_comb begin
		next_state = state;
		case (state)
			idle:      next_state = stb_start_r ? start : idle;
			start:     next_state = proc_run;
			proc_run:  next_state = procdone_r ? elem_busy : proc_run;
			elem_busy: next_state = nobusy_r ? more_shot : elem_busy;
			more_shot: next_state = shot_more ? shot_add : done;
			shot_add:  next_state = start;
			done:      next_state = idle;
			default:   next_state = idle;
		endcase
	end

	// registered core conditions and next-shot compare
	always_ff @(posedge dspif) begin
		procdone_r <= &procdone_core;
		nobusy_r <= &nobusy_core;
		next_shot_cnt <= shot_cnt + 1'b1;
		// nshot of zero never finishes
		shot_more <= (next_shot_cnt != nshot_r) || (nshot_r == '0);
	end

	always_ff @(posedge dspif) begin
		if (reset) begin
			state <= idle;
			stb_start_r <= 1'b0;
			nshot_r <= '0;
			shot_cnt <= '0;
			shot_count <= '0;
			proc_start <= 1'b0;
			proc_reset <= 1'b1;
			last_shot_done <= 1'b0;
		end else begin
			state <= next_state;
			stb_start_r <= stb_start;
			// outputs follow the state being entered
			proc_start <= (next_state == start);
			proc_reset <= !(next_state inside {start, proc_run});
			last_shot_done <= (next_state == done);
			if (state == idle) begin
				nshot_r <= nshot;
			end
			if (next_state == idle || next_state == done) begin
				shot_cnt <= '0;
			end else if (next_state == shot_add) begin
				shot_cnt <= next_shot_cnt;
				shot_count <= next_shot_cnt;
			end
			// count holds after done until a new run clears it
			if (state == idle && stb_start_r) begin
				shot_count <= '0;
			end
		end
	end

	// set wins over the clear of the done flag
	always_ff @(posedge dspif) begin
		if (reset) begin
			proc_done <= 1'b0;
		end else if (procdone_r) begin
			proc_done <= 1'b1;
		end else if (proc_start) begin
			proc_done <= 1'b0;
		end
	end

endmodule

// File: hw/dsp_top.sv
// ========================================
// dsp top level
// readout path and shot sequencer
// ========================================

module dsp_top (
	input  logic dspif,
	input  logic reset,
	// readout path
	input  logic [dsp_pkg::adc_w-1:0] adc,
	input  logic [dsp_pkg::dac_w-1:0] dac [dsp_pkg::n_dac],
	input  logic [dsp_pkg::bbsel_w-1:0] mixbb1_sel,
	input  logic [dsp_pkg::bbsel_w-1:0] mixbb2_sel,
	input  logic [dsp_pkg::shift_w-1:0] shift,
	input  logic [dsp_pkg::n_chan-1:0] gate,
	input  logic resetacc,
	output logic [dsp_pkg::n_chan-1:0] we_accbuf,
	output logic [dsp_pkg::accbuf_addr_w-1:0] addr_accbuf [dsp_pkg::n_chan],
	output logic [2*dsp_pkg::acc_half_w-1:0] data_accbuf [dsp_pkg::n_chan],
	output logic [dsp_pkg::n_chan-1:0] meas,
	output logic [dsp_pkg::n_chan-1:0] meas_valid,
	// sequencer
	input  logic stb_start,
	input  logic [dsp_pkg::shot_w-1:0] nshot,
	input  logic [dsp_pkg::n_core-1:0] procdone_core,
	input  logic [dsp_pkg::n_core-1:0] nobusy_core,
	output logic proc_start,
	output logic proc_reset,
	output logic proc_done,
	output logic last_shot_done,
	output logic [dsp_pkg::shot_w-1:0] shot_count
);
	import dsp_pkg::*;

	logic [adc_w-1:0] mixbb [n_chan];
	logic [n_chan-1:0] acc_valid;
	acc_word_t acc_data [n_chan];

	baseband_select u_bbsel (
		.dspif(dspif), .reset(reset), .adc(adc), .dac(dac),
		.mixbb1_sel(mixbb1_sel), .mixbb2_sel(mixbb2_sel), .mixbb(mixbb)
	);

	readout_accumulator u_acc (
		.dspif(dspif), .reset(reset), .mixbb(mixbb), .gate(gate), .shift(shift),
		.acc_valid(acc_valid), .acc_data(acc_data)
	);

	accbuf_writer u_writer (
		.dspif(dspif), .reset(reset), .acc_valid(acc_valid), .acc_data(acc_data),
		.resetacc(resetacc), .we_accbuf(we_accbuf), .addr_accbuf(addr_accbuf),
		.data_accbuf(data_accbuf), .meas(meas), .meas_valid(meas_valid)
	);

	shot_sequencer u_seq (
		.dspif(dspif), .reset(reset), .stb_start(stb_start), .nshot(nshot),
		.procdone_core(procdone_core), .nobusy_core(nobusy_core),
		.proc_start(proc_start), .proc_reset(proc_reset), .proc_done(proc_done),
		.last_shot_done(last_shot_done), .shot_count(shot_count)
	);

endmodule

// File: verif/tb_dsp.sv
// ========================================
// dsp testbench
// vector driven readout and sequencer checks
// against an fs/4 reference model
// ========================================

module tb_dsp;
	timeunit 1ns;
	timeprecision 1ps;
	import dsp_pkg::*;

	logic dspif;
	logic reset;
	logic [adc_w-1:0] adc;
	logic [dac_w-1:0] dac [n_dac];
	logic [bbsel_w-1:0] mixbb1_sel;
	logic [bbsel_w-1:0] mixbb2_sel;
	logic [shift_w-1:0] shift;
	logic [n_chan-1:0] gate;
	logic resetacc;
	logic [n_chan-1:0] we_accbuf;
	logic [accbuf_addr_w-1:0] addr_accbuf [n_chan];
	logic [2*acc_half_w-1:0] data_accbuf [n_chan];
	logic [n_chan-1:0] meas;
	logic [n_chan-1:0] meas_valid;
	logic stb_start;
	logic [shot_w-1:0] nshot;
	logic [n_core-1:0] procdone_core;
	logic [n_core-1:0] nobusy_core;
	logic proc_start;
	logic proc_reset;
	logic proc_done;
	logic last_shot_done;
	logic [shot_w-1:0] shot_count;

	// reference model state
	logic [31:0] lfsr;
	logic [2*acc_half_w-1:0] exp_word [n_chan];
	logic [accbuf_addr_w-1:0] exp_addr [n_chan];
	// stream value kept by the hold code
	logic [adc_w-1:0] held_word [n_chan];
	int writes [n_chan];
	int meas_seen [n_chan];
	longint cycles;
	// grows by 2000 cycles per vector line
	longint limit = 2000;

	dsp_top UUT (.*);

	initial dspif = 1'b0;
	always #5 dspif = ~dspif;

	task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
		if (got !== want) begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic tick();
		@(posedge dspif);
		#1;
	endtask

	// galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic next_random_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic logic [63:0] random_word();
		logic [63:0] w;
		w = '0;
		for (int i = 0; i < 64; i++) begin
			w = {w[62:0], next_random_bit()};
		end
		return w;
	endfunction

	// one gate window on both channels with the model following the driven words
	task automatic run_window(input logic [1:0] s1, input logic [1:0] s2,
		input logic [4:0] sh, input int len, input int target);
		logic signed [31:0] sx [n_chan];
		logic signed [31:0] sy [n_chan];
		logic signed [31:0] s [4];
		logic [63:0] dus [n_dac];
		logic [63:0] picked;
		logic [1:0] sel;
		mixbb1_sel = s1;
		mixbb2_sel = s2;
		shift = sh;
		// selectors settle before the window opens
		repeat (3) tick();
		for (int c = 0; c < n_chan; c++) begin
			sx[c] = '0;
			sy[c] = '0;
		end
		for (int k = 0; k < len + 2; k++) begin
			tick();
			// two cycles of select pipeline ahead of the gate
			gate = (k >= 2) ? '1 : '0;
			// inputs keep their last words once the window is filled
			if (k < len) begin
				adc = random_word();
				for (int d = 0; d < n_dac; d++) begin
					for (int j = 0; j < 4; j++) begin
						dac[d][j*64 +: 64] = random_word();
						// dac samples 0, 4, 8, 12
						dus[d][j*16 +: 16] = dac[d][j*64 +: 16];
					end
				end
				for (int c = 0; c < n_chan; c++) begin
					sel = (c == 0) ? s1 : s2;
					case (sel)
						2'd0: picked = adc;
						2'd1: picked = dus[2*c];
						2'd2: picked = dus[2*c+1];
						default: picked = held_word[c];
					endcase
					held_word[c] = picked;
					for (int q = 0; q < 4; q++) begin
						s[q] = {{16{picked[q*16+15]}}, picked[q*16 +: 16]};
					end
					sx[c] = sx[c] + s[0] - s[2];
					sy[c] = sy[c] + s[3] - s[1];
				end
			end
		end
		tick();
		gate = '0;
		for (int c = 0; c < n_chan; c++) begin
			exp_word[c] = {sx[c] >>> sh, sy[c] >>> sh};
		end
		while (meas_seen[0] < target || meas_seen[1] < target) begin
			tick();
		end
	endtask

	task automatic run_shots(input int nsh, input int nexp);
		int starts;
		int lasts;
		logic was_start;
		nshot = nsh;
		tick();
		stb_start = 1'b1;
		tick();
		stb_start = 1'b0;
		starts = 0;
		lasts = 0;
		was_start = 1'b0;
		while (lasts == 0) begin
			tick();
			// done flag drops right behind each start pulse
			if (was_start) begin
				check(64'(proc_done), 64'(0), "proc_done after proc_start");
			end
			was_start = proc_start;
			if (proc_start) begin
				starts++;
			end
			if (last_shot_done) begin
				lasts++;
				check(64'(proc_done), 64'(1), "proc_done at last shot");
			end
		end
		repeat (4) begin
			tick();
			if (proc_start) begin
				starts++;
			end
			if (last_shot_done) begin
				lasts++;
			end
		end
		check(64'(starts), 64'(nexp), "proc_start pulse count");
		check(64'(lasts), 64'(1), "last_shot_done pulse count");
		check(64'(shot_count), 64'(nsh - 1), "shot_count");
		check(64'(proc_reset), 64'(1), "proc_reset while idle");
	endtask

	// write monitor whose address model locks at all ones
	initial begin
		logic clear_seen;
		logic in_reset;
		for (int c = 0; c < n_chan; c++) begin
			writes[c] = 0;
			meas_seen[c] = 0;
			exp_addr[c] = '0;
		end
		forever begin
			@(posedge dspif);
			clear_seen = resetacc;
			in_reset = reset;
			#1;
			for (int c = 0; c < n_chan; c++) begin
				if (!in_reset && we_accbuf[c]) begin
					check(64'(addr_accbuf[c]), 64'(exp_addr[c]), "write address");
					check(data_accbuf[c], exp_word[c], "accumulated word");
					writes[c]++;
					// a write beside the clear keeps its address
					if (!clear_seen && exp_addr[c] != '1) begin
						exp_addr[c] = exp_addr[c] + accbuf_addr_w'(1);
					end
				end
				if (clear_seen) begin
					exp_addr[c] = '0;
				end
				if (!in_reset && meas_valid[c]) begin
					check(64'(meas[c]), 64'(exp_word[c][63]), "measurement bit");
					meas_seen[c]++;
				end
			end
		end
	end

	// cores finish 4 cycles into a run and idle while held in reset
	initial begin
		int run_cycles;
		procdone_core = '0;
		nobusy_core = '1;
		run_cycles = 0;
		forever begin
			tick();
			if (proc_reset) begin
				procdone_core = '0;
				nobusy_core = '1;
				run_cycles = 0;
			end else begin
				nobusy_core = '0;
				run_cycles++;
				if (run_cycles == 4) begin
					procdone_core = '1;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= limit) begin
			@(posedge dspif);
			cycles++;
		end
		$display("watchdog timeout, the run stalled after %0d cycles", cycles);
		$display("Regression failed");
		$fatal(1);
	end

	initial begin
		int fd;
		int r;
		int sel1;
		int sel2;
		int sh;
		int len;
		int nwin;
		int nsh;
		int nexp;
		int base [n_chan];
		string kind;
		logic [8*128-1:0] rest;
		reset = 1'b1;
		adc = '0;
		for (int d = 0; d < n_dac; d++) begin
			dac[d] = '0;
		end
		for (int c = 0; c < n_chan; c++) begin
			held_word[c] = '0;
		end
		mixbb1_sel = '0;
		mixbb2_sel = '0;
		shift = '0;
		gate = '0;
		resetacc = 1'b0;
		stb_start = 1'b0;
		nshot = '0;
		lfsr = 32'hb37a;
		repeat (3) tick();
		reset = 1'b0;
		fd = $fopen("verif/dsp_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file verif/dsp_vectors.txt");
			$display("Regression failed");
			$fatal(1);
		end
		while ($fscanf(fd, "%s", kind) == 1) begin
			limit = limit + 2000;
			if (kind == "#") begin
				r = $fgets(rest, fd);
			end else if (kind == "A") begin
				r = $fscanf(fd, "%d %d %d %d %d", sel1, sel2, sh, len, nwin);
				for (int c = 0; c < n_chan; c++) begin
					base[c] = writes[c];
				end
				for (int w = 0; w < nwin; w++) begin
					run_window(sel1[1:0], sel2[1:0], sh[4:0], len, base[0] + w + 1);
				end
				// no extra strobes behind the last window
				repeat (3) tick();
				for (int c = 0; c < n_chan; c++) begin
					check(64'(writes[c] - base[c]), 64'(nwin), "write count");
					check(64'(meas_seen[c] - base[c]), 64'(nwin), "measurement count");
					check(64'(addr_accbuf[c]), 64'(exp_addr[c]), "address after window");
				end
			end else if (kind == "R") begin
				resetacc = 1'b1;
				tick();
				resetacc = 1'b0;
				repeat (3) tick();
				for (int c = 0; c < n_chan; c++) begin
					check(64'(addr_accbuf[c]), 64'(0), "address after resetacc");
				end
			end else if (kind == "S") begin
				r = $fscanf(fd, "%d %d", nsh, nexp);
				run_shots(nsh, nexp);
			end else begin
				$display("unknown line kind %s in the vector file", kind);
				$display("Regression failed");
				$fatal(1);
			end
		end
		$fclose(fd);
		repeat (4) tick();
		$display("Regression passed");
		$finish;
	end

endmodule

// File: filelist.f
hw/dsp_pkg.sv
hw/baseband_select.sv
hw/readout_accumulator.sv
hw/accbuf_writer.sv
hw/shot_sequencer.sv
hw/dsp_top.sv
verif/tb_dsp.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dsp regression with verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module tb_dsp -o tb_dsp
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_dsp)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verif/dsp_vectors.txt
# A sel1 sel2 shift gate_len windows (windows = expected writes per channel)
# R = resetacc pulse, S nshot expected_proc_starts
A 0 0 0 4 2
A 1 2 3 6 1
A 2 1 0 8 1
A 0 3 5 3 1
A 3 0 1 5 1
A 1 1 12 16 2
A 2 0 31 4 1
R
A 2 2 2 2 3
A 0 0 0 1 260
S 1 1
S 3 3
R
A 0 1 4 5 1
